/* project.f */
verilog/glay_pkg.sv
verilog/kernel_control.sv
verilog/read_engine.sv
verilog/reduce_unit.sv
verilog/write_engine.sv
verilog/glay_kernel_top.sv
verif/glay_kernel_tb.sv

/* Makefile */
# Verilator build and run of the reduction kernel testbench
TOP := glay_kernel_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then \
		echo "testbench reported failure"; \
		exit 1; \
	fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/glay_kernel_tb.sv */
/* Testbench for the reduction kernel. Runs a table of jobs through the host handshake,
   answers both four-phase memory ports with random delays and checks every result. */
`timescale 1ns/100ps
`default_nettype none

module glay_kernel_tb;

    import glay_pkg::*;

    // One job per row, expected result filled in once memory is loaded
    typedef struct packed {
        logic [31:0] base;
        logic [31:0] count;
        logic [31:0] result_addr;
        logic [31:0] flags;
        logic [31:0] expected;
    } job_row;

    logic                     ap_clk;
    logic                     areset_control;
    logic                     ap_start;
    kernel_descriptor_payload descriptor_in;
    logic                     ap_ready;
    logic                     ap_done;
    logic                     ap_idle;
    mem_read_req              rd_req;
    mem_read_rsp              rd_rsp;
    mem_write_req             wr_req;
    mem_write_rsp             wr_rsp;

    // Memory model state and transfer logs
    logic [31:0] mem [256];
    logic [31:0] rd_addr_log [$];
    int          rd_phase;
    int          rd_delay;
    int          wr_phase;
    int          wr_delay;
    int          wr_count;
    logic [31:0] wr_addr_last;
    logic [31:0] wr_data_last;

    job_row job_table [$];
    int     error_count;
    int     cycle_count;
    int     timeout_limit;

    glay_kernel_top u_glay_kernel_top (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .ap_start       (ap_start),
        .descriptor_in  (descriptor_in),
        .ap_ready       (ap_ready),
        .ap_done        (ap_done),
        .ap_idle        (ap_idle),
        .rd_req         (rd_req),
        .rd_rsp         (rd_rsp),
        .wr_req         (wr_req),
        .wr_rsp         (wr_rsp)
    );

    // 8 ns clock
    initial begin
        ap_clk = 1'b0;
        forever #4 ap_clk = ~ap_clk;
    end

    // --------------------------------------------------
    // Memory responders, four-phase with 0 to 3 cycle delays
    // --------------------------------------------------
    initial begin
        rd_rsp   = '0;
        rd_phase = 0;
        rd_delay = 0;
        forever begin
            @(posedge ap_clk);
            if (areset_control) begin
                rd_rsp   <= '0;
                rd_phase <= 0;
            end else begin
                case (rd_phase)
                    // Waiting for req
                    0: if (rd_req.req) begin
                        rd_delay <= $urandom_range(3, 0);
                        rd_phase <= 1;
                    end
                    // Delay, then ack with data
                    1: if (rd_delay == 0) begin
                        rd_rsp.ack   <= 1'b1;
                        rd_rsp.rdata <= mem[rd_req.addr[7:0]];
                        rd_addr_log.push_back(rd_req.addr);
                        rd_phase     <= 2;
                    end else begin
                        rd_delay <= rd_delay - 1;
                    end
                    // Waiting for req to drop
                    2: if (!rd_req.req) begin
                        rd_delay <= $urandom_range(3, 0);
                        rd_phase <= 3;
                    end
                    default: if (rd_delay == 0) begin
                        rd_rsp.ack <= 1'b0;
                        rd_phase   <= 0;
                    end else begin
                        rd_delay <= rd_delay - 1;
                    end
                endcase
            end
        end
    end

    initial begin
        wr_rsp       = '0;
        wr_phase     = 0;
        wr_delay     = 0;
        wr_count     = 0;
        wr_addr_last = '0;
        wr_data_last = '0;
        forever begin
            @(posedge ap_clk);
            if (areset_control) begin
                wr_rsp   <= '0;
                wr_phase <= 0;
            end else begin
                case (wr_phase)
                    0: if (wr_req.req) begin
                        wr_delay <= $urandom_range(3, 0);
                        wr_phase <= 1;
                    end
                    // Capture the stored word with the ack
                    1: if (wr_delay == 0) begin
                        wr_rsp.ack   <= 1'b1;
                        wr_addr_last <= wr_req.addr;
                        wr_data_last <= wr_req.wdata;
                        wr_count     <= wr_count + 1;
                        wr_phase     <= 2;
                    end else begin
                        wr_delay <= wr_delay - 1;
                    end
                    2: if (!wr_req.req) begin
                        wr_delay <= $urandom_range(3, 0);
                        wr_phase <= 3;
                    end
                    default: if (wr_delay == 0) begin
                        wr_rsp.ack <= 1'b0;
                        wr_phase   <= 0;
                    end else begin
                        wr_delay <= wr_delay - 1;
                    end
                endcase
            end
        end
    end

    // Run limit, zero until the job table is known
    initial begin
        cycle_count = 0;
        while (timeout_limit == 0 || cycle_count < timeout_limit) begin
            @(posedge ap_clk);
            cycle_count++;
        end
        $display("timeout: jobs did not finish within %0d cycles", timeout_limit);
        $display("Simulation FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Reference model and helpers
    // --------------------------------------------------
    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Sum mod 2^32 or unsigned max, with the byte swaps of the flag bits
    function automatic logic [31:0] reduce_expected(input job_row row);
        logic [31:0] acc;
        logic [31:0] word;
        acc = '0;
        for (int i = 0; i < int'(row.count); i++) begin
            word = mem[8'(row.base + 32'(i))];
            if (row.flags[flag_endian_read]) begin
                word = swap_bytes(word);
            end
            if (row.flags[flag_reduce_max]) begin
                acc = (word > acc) ? word : acc;
            end else begin
                acc = acc + word;
            end
        end
        if (row.flags[flag_endian_write]) begin
            acc = swap_bytes(acc);
        end
        return acc;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        assert (got === expected) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic add_job(input logic [31:0] base_addr, input logic [31:0] word_count,
                           input logic [31:0] result_addr, input logic [31:0] flag_bits);
        job_row row;
        row             = '0;
        row.base        = base_addr;
        row.count       = word_count;
        row.result_addr = result_addr;
        row.flags       = flag_bits;
        job_table.push_back(row);
    endtask

    // Host side of one job, then the result and read order checks
    task automatic apply_job(input job_row row);
        kernel_descriptor_payload payload;
        int                       log_start;
        int                       writes_before;
        payload          = '0;
        payload.buffer_0 = row.base;
        payload.buffer_1 = row.count;
        payload.buffer_2 = row.result_addr;
        payload.buffer_5 = 32'h5a5a_0005;
        payload.buffer_9 = row.flags;
        log_start        = rd_addr_log.size();
        writes_before    = wr_count;
        @(posedge ap_clk);
        descriptor_in <= payload;
        ap_start      <= 1'b1;
        @(posedge ap_clk);
        while (!ap_ready) @(posedge ap_clk);
        ap_start <= 1'b0;
        @(posedge ap_clk);
        while (!ap_done) @(posedge ap_clk);
        compare_word("write count", 32'(wr_count - writes_before), 32'd1);
        compare_word("wr_req.addr", wr_addr_last, row.result_addr);
        compare_word("wr_req.wdata", wr_data_last, row.expected);
        compare_word("read count", 32'(rd_addr_log.size() - log_start), row.count);
        for (int i = log_start; i < rd_addr_log.size(); i++) begin
            compare_word("rd_req.addr", rd_addr_log[i], row.base + 32'(i - log_start));
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        job_row row;
        int     total;
        error_count    = 0;
        timeout_limit  = 0;
        areset_control = 1'b1;
        ap_start       = 1'b0;
        descriptor_in  = '0;
        void'($urandom(32'ha352));
        for (int i = 0; i < 256; i++) begin
            mem[8'(i)] = $urandom();
        end

        // base, count, result address, flags (bit 0 rd swap, bit 1 wr swap, bit 2 max)
        add_job(32'h10, 32'd8,  32'hf0, 32'h0);
        add_job(32'h20, 32'd12, 32'hf1, 32'h4);
        add_job(32'h30, 32'd6,  32'hf2, 32'h1);
        add_job(32'h38, 32'd6,  32'hf3, 32'h2);
        add_job(32'h40, 32'd10, 32'hf4, 32'h7);
        add_job(32'h50, 32'd0,  32'hf5, 32'h0);
        add_job(32'h60, 32'd16, 32'hf6, 32'h3);
        add_job(32'h80, 32'd1,  32'hf7, 32'h4);

        total = 200;
        for (int j = 0; j < job_table.size(); j++) begin
            row          = job_table[j];
            row.expected = reduce_expected(row);
            job_table[j] = row;
            total        = total + int'(row.count) * 20;
        end
        timeout_limit = total;

        repeat (5) @(posedge ap_clk);
        areset_control <= 1'b0;
        @(posedge ap_clk);
        compare_word("ap_idle", 32'(ap_idle), 32'd1);
        compare_word("ap_ready", 32'(ap_ready), 32'd0);
        compare_word("ap_done", 32'(ap_done), 32'd0);
        compare_word("rd_req.req", 32'(rd_req.req), 32'd0);
        compare_word("wr_req.req", 32'(wr_req.req), 32'd0);

        for (int j = 0; j < job_table.size(); j++) begin
            apply_job(job_table[j]);
        end

        $display("jobs run %0d, errors %0d", job_table.size(), error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : glay_kernel_tb

`default_nettype wire

/* verilog/glay_kernel_top.sv */
/* Kernel top level. Wires the control block to the read, reduce and write datapath
   and exposes the host control levels and both memory ports. */
`timescale 1ns/100ps
`default_nettype none

module glay_kernel_top (
    input  logic                               ap_clk,
    input  logic                               areset_control,
    input  logic                               ap_start,
    input  glay_pkg::kernel_descriptor_payload descriptor_in,
    output logic                               ap_ready,
    output logic                               ap_done,
    output logic                               ap_idle,
    output glay_pkg::mem_read_req              rd_req,
    input  glay_pkg::mem_read_rsp              rd_rsp,
    output glay_pkg::mem_write_req             wr_req,
    input  glay_pkg::mem_write_rsp             wr_rsp
);

    import glay_pkg::*;

    control_chain_in  control_in;
    control_chain_out control_out;
    kernel_descriptor descriptor;

    logic        read_idle;
    logic        word_valid;
    logic [31:0] word_data;
    logic        word_last;
    logic        result_valid;
    logic [31:0] result_data;
    logic        write_done;

    // --------------------------------------------------
    // Control chain
    // --------------------------------------------------
    assign control_in = '{ap_start: ap_start, setup: read_idle, done: write_done};

    assign ap_ready = control_out.ap_ready;
    assign ap_done  = control_out.ap_done;
    assign ap_idle  = control_out.ap_idle;

    kernel_control u_kernel_control (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .control_in     (control_in),
        .control_out    (control_out),
        .descriptor_in  (descriptor_in),
        .descriptor_out (descriptor)
    );

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    read_engine u_read_engine (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .descriptor     (descriptor),
        .endian_read    (control_out.endian_read),
        .rd_req         (rd_req),
        .rd_rsp         (rd_rsp),
        .word_valid     (word_valid),
        .word_data      (word_data),
        .word_last      (word_last),
        .idle           (read_idle)
    );

    reduce_unit u_reduce_unit (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .descriptor     (descriptor),
        .word_valid     (word_valid),
        .word_data      (word_data),
        .word_last      (word_last),
        .result_valid   (result_valid),
        .result_data    (result_data)
    );

    write_engine u_write_engine (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .descriptor     (descriptor),
        .endian_write   (control_out.endian_write),
        .result_valid   (result_valid),
        .result_data    (result_data),
        .wr_req         (wr_req),
        .wr_rsp         (wr_rsp),
        .done           (write_done)
    );

endmodule : glay_kernel_top

`default_nettype wire

/* verilog/write_engine.sv */
/* Stores the reduced result over the four-phase write port, optionally byte-swapped,
   and raises done for the control block once the handshake has closed. */
`timescale 1ns/100ps
`default_nettype none

module write_engine (
    input  logic                       ap_clk,
    input  logic                       areset_control,
    input  glay_pkg::kernel_descriptor descriptor,
    input  logic                       endian_write,
    input  logic                       result_valid,
    input  logic [31:0]                result_data,
    output glay_pkg::mem_write_req     wr_req,
    input  glay_pkg::mem_write_rsp     wr_rsp,
    output logic                       done
);

    logic        req_q;
    logic        in_flight;
    logic        launch;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;

    // One write per job, and only once ack is low
    assign launch = result_valid && !in_flight && !done && !wr_rsp.ack;

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            req_q     <= 1'b0;
            in_flight <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (!descriptor.valid) begin
                done <= 1'b0;
            end
            if (launch) begin
                in_flight <= 1'b1;
                req_q     <= 1'b1;
            end else if (req_q && wr_rsp.ack) begin
                req_q <= 1'b0;
            end else if (in_flight && !req_q && !wr_rsp.ack) begin
                // Handshake closed
                in_flight <= 1'b0;
                done      <= 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (launch) begin
            addr_q  <= descriptor.payload.buffer_2;
            wdata_q <= endian_write ? {result_data[7:0], result_data[15:8],
                                       result_data[23:16], result_data[31:24]}
                                    : result_data;
        end
    end

    assign wr_req = '{req: req_q, addr: addr_q, wdata: wdata_q};

    // Four-phase order on the write port
    a_req_after_ack: assert property (@(posedge ap_clk) disable iff (areset_control)
        $rose(wr_req.req) |-> !wr_rsp.ack)
        else $error("write req rose while ack high");

endmodule : write_engine

`default_nettype wire

/* verilog/reduce_unit.sv */
/* Folds the word stream from the read engine into one 32-bit result, either the
   modular sum or the largest unsigned word, selected by the reduce flag. */
`timescale 1ns/100ps
`default_nettype none

module reduce_unit (
    input  logic                       ap_clk,
    input  logic                       areset_control,
    input  glay_pkg::kernel_descriptor descriptor,
    input  logic                       word_valid,
    input  logic [31:0]                word_data,
    input  logic                       word_last,
    output logic                       result_valid,
    output logic [31:0]                result_data
);

    import glay_pkg::*;

    logic        valid_q;
    logic        job_start;
    reduce_op_t  op;
    logic [31:0] acc;

    assign job_start = descriptor.valid && !valid_q;

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            valid_q      <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            valid_q <= descriptor.valid;
            // Held until the job is released
            if (!descriptor.valid) begin
                result_valid <= 1'b0;
            end else if (word_last) begin
                result_valid <= 1'b1;
            end
        end
    end

    // Accumulator, zero for an empty run
    always_ff @(posedge ap_clk) begin
        if (job_start) begin
            op  <= reduce_op_t'(descriptor.payload.buffer_9[flag_reduce_max]);
            acc <= '0;
        end else if (word_valid) begin
            if (op == op_max) begin
                acc <= (word_data > acc) ? word_data : acc;
            end else begin
                acc <= acc + word_data;  // wraps mod 2^32
            end
        end
    end

    assign result_data = acc;

endmodule : reduce_unit

`default_nettype wire

/* verilog/read_engine.sv */
/* Word fetch over the four-phase read port. Starts on the rising edge of descriptor
   valid and passes each word, optionally byte-swapped, on to the reduce unit. */
`timescale 1ns/100ps
`default_nettype none

module read_engine (
    input  logic                       ap_clk,
    input  logic                       areset_control,
    input  glay_pkg::kernel_descriptor descriptor,
    input  logic                       endian_read,
    output glay_pkg::mem_read_req      rd_req,
    input  glay_pkg::mem_read_rsp      rd_rsp,
    output logic                       word_valid,
    output logic [31:0]                word_data,
    output logic                       word_last,
    output logic                       idle
);

    logic        valid_q;
    logic        job_start;
    logic        busy;
    logic        req_q;
    logic        take_word;
    logic [31:0] addr_q;
    logic [31:0] remaining;

    assign job_start = descriptor.valid && !valid_q;
    // Ack seen while req is up completes one transfer
    assign take_word = req_q && rd_rsp.ack;

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            valid_q    <= 1'b0;
            busy       <= 1'b0;
            req_q      <= 1'b0;
            remaining  <= '0;
            word_valid <= 1'b0;
            word_last  <= 1'b0;
        end else begin
            valid_q    <= descriptor.valid;
            word_valid <= 1'b0;
            word_last  <= 1'b0;
            if (job_start) begin
                remaining <= descriptor.payload.buffer_1;
                // Empty run only signals the end
                if (descriptor.payload.buffer_1 == '0) begin
                    word_last <= 1'b1;
                end else begin
                    busy  <= 1'b1;
                    req_q <= 1'b1;
                end
            end else if (take_word) begin
                req_q      <= 1'b0;
                word_valid <= 1'b1;
                word_last  <= (remaining == 32'd1);
                remaining  <= remaining - 32'd1;
            end else if (busy && !req_q && !rd_rsp.ack) begin
                // Ack is low again, next word or finish
                if (remaining != '0) begin
                    req_q <= 1'b1;
                end else begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Address and data path
    always_ff @(posedge ap_clk) begin
        if (job_start) begin
            addr_q <= descriptor.payload.buffer_0;
        end else if (take_word) begin
            addr_q    <= addr_q + 32'd1;
            word_data <= endian_read ? {rd_rsp.rdata[7:0], rd_rsp.rdata[15:8],
                                        rd_rsp.rdata[23:16], rd_rsp.rdata[31:24]}
                                     : rd_rsp.rdata;
        end
    end

    assign rd_req = '{req: req_q, addr: addr_q};
    assign idle   = !busy;

    // Address held for the whole request phase
    a_addr_stable: assert property (@(posedge ap_clk) disable iff (areset_control)
        rd_req.req |=> !rd_req.req || $stable(rd_req.addr))
        else $error("read address changed while req high");

endmodule : read_engine

`default_nettype wire

/* verilog/kernel_control.sv */
/* Host-side control for the reduction kernel: user-managed sync FSM with ap_start,
   ap_ready and ap_done levels. Registers the descriptor and hands it to the datapath. */
`timescale 1ns/100ps
`default_nettype none

module kernel_control (
    input  logic                               ap_clk,
    input  logic                               areset_control,
    input  glay_pkg::control_chain_in          control_in,
    output glay_pkg::control_chain_out         control_out,
    input  glay_pkg::kernel_descriptor_payload descriptor_in,
    output glay_pkg::kernel_descriptor         descriptor_out
);

    import glay_pkg::*;

    // Registered inputs
    logic ap_start_reg;
    logic setup_reg;
    logic done_reg;

    kernel_descriptor_payload descriptor_in_reg;
    kernel_descriptor_payload payload_q;

    // First output stage, decoded from the state
    control_chain_out status_q;
    logic             desc_valid_q;
    logic             desc_valid_out;

    user_managed_sync_state current_state;
    user_managed_sync_state next_state;

    // --------------------------------------------------
    // Input registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_start_reg <= 1'b0;
            setup_reg    <= 1'b1;
            done_reg     <= 1'b0;
        end else begin
            ap_start_reg <= control_in.ap_start;
            setup_reg    <= control_in.setup;
            done_reg     <= control_in.done;
        end
    end

    // Descriptor pipe, two cycles in to out
    always_ff @(posedge ap_clk) begin
        descriptor_in_reg <= descriptor_in;
        payload_q         <= descriptor_in_reg;
    end

    // --------------------------------------------------
    // Sync FSM
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            current_state <= sync_reset;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            sync_reset: next_state = sync_idle;
            sync_idle:  next_state = sync_setup;
            // Wait for the host
            sync_setup: if (ap_start_reg) next_state = sync_ready;
            // Hold until the datapath reports idle
            sync_ready: if (setup_reg) next_state = sync_start;
            sync_start: next_state = sync_busy;
            sync_busy:  if (done_reg) next_state = sync_done;
            // ap_done held until the next job arrives
            sync_done:  if (ap_start_reg) next_state = sync_ready;
            default:    next_state = sync_reset;
        endcase
    end

    // --------------------------------------------------
    // Output stages
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            status_q     <= control_out_reset;
            desc_valid_q <= 1'b0;
        end else begin
            status_q.ap_ready <= (current_state == sync_ready);
            status_q.ap_done  <= (current_state == sync_done);
            status_q.ap_idle  <= current_state inside {sync_reset, sync_idle,
                                                       sync_setup, sync_done};
            status_q.start    <= current_state inside {sync_setup, sync_ready,
                                                       sync_start, sync_busy};
            desc_valid_q      <= current_state inside {sync_start, sync_busy};
            // Endian flags only while a job runs
            status_q.endian_read  <= current_state inside {sync_start, sync_busy} &&
                                     descriptor_in_reg.buffer_9[flag_endian_read];
            status_q.endian_write <= current_state inside {sync_start, sync_busy} &&
                                     descriptor_in_reg.buffer_9[flag_endian_write];
        end
    end

    // Second stage, lines up with the descriptor payload
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            control_out    <= control_out_reset;
            desc_valid_out <= 1'b0;
        end else begin
            control_out    <= status_q;
            desc_valid_out <= desc_valid_q;
        end
    end

    assign descriptor_out = '{valid: desc_valid_out, payload: payload_q};

    // Host never sees ready and done in the same cycle
    a_ready_done_excl: assert property (@(posedge ap_clk) disable iff (areset_control)
        !(control_out.ap_ready && control_out.ap_done))
        else $error("ap_ready and ap_done high together");

endmodule : kernel_control

`default_nettype wire

/* verilog/glay_pkg.sv */
/* Shared types for the reduction kernel: host descriptor, control chain and memory ports.
   Every RTL module and the testbench compile against this package first. */
`default_nettype none

package glay_pkg;

    // --------------------------------------------------
    // Host descriptor
    // --------------------------------------------------
    // Ten host words, buffer_3 to buffer_8 ride along unused
    typedef struct packed {
        logic [31:0] buffer_0;  // Read base word address
        logic [31:0] buffer_1;  // Word count
        logic [31:0] buffer_2;  // Result word address
        logic [31:0] buffer_3;
        logic [31:0] buffer_4;
        logic [31:0] buffer_5;
        logic [31:0] buffer_6;
        logic [31:0] buffer_7;
        logic [31:0] buffer_8;
        logic [31:0] buffer_9;  // Flag bits
    } kernel_descriptor_payload;

    typedef struct packed {
        logic                     valid;
        kernel_descriptor_payload payload;
    } kernel_descriptor;

    // Flag positions inside buffer_9
    localparam int flag_endian_read  = 0;
    localparam int flag_endian_write = 1;
    localparam int flag_reduce_max   = 2;

    // --------------------------------------------------
    // Control chain
    // --------------------------------------------------
    typedef struct packed {
        logic ap_start;
        logic setup;
        logic done;
    } control_chain_in;

    typedef struct packed {
        logic ap_ready;
        logic ap_done;
        logic ap_idle;
        logic start;
        logic endian_read;
        logic endian_write;
    } control_chain_out;

    // Idle high, everything else low
    localparam control_chain_out control_out_reset = 6'b001000;

    typedef enum logic [2:0] {
        sync_reset,
        sync_idle,
        sync_setup,
        sync_ready,
        sync_start,
        sync_busy,
        sync_done
    } user_managed_sync_state;

    // --------------------------------------------------
    // Four-phase memory ports
    // --------------------------------------------------
    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } mem_read_req;

    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } mem_read_rsp;

    typedef struct packed {
        logic        req;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_write_req;

    typedef struct packed {
        logic ack;
    } mem_write_rsp;

    typedef enum logic {
        op_sum,
        op_max
    } reduce_op_t;

endpackage : glay_pkg

`default_nettype wire
